/* ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    localparam int ROB_DEPTH  = 16;          // Reorder buffer entries
    localparam int TAG_W      = 4;           // Entry index width
    localparam int XLEN       = 32;          // Data path width
    localparam int REG_W      = 5;           // Destination register number
    localparam int MUL_STAGES = 3;           // Multiplier pipeline depth

    typedef enum logic [3:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLL,                              // Shift by b[4:0]
        OP_MUL,                              // Low half of product
        OP_DIVU,                             // Unsigned quotient
        OP_REMU                              // Unsigned remainder
    } op_e;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_MUL,
        UNIT_DIV
    } unit_e;

    // Steers an operation to its execution unit
    function automatic unit_e unit_of(input op_e op);
        case (op)
            OP_MUL:          return UNIT_MUL;
            OP_DIVU, OP_REMU: return UNIT_DIV;
            default:         return UNIT_ALU;
        endcase
    endfunction

endpackage

`default_nettype wire

/* reorder_buffer.sv */
`default_nettype none

module reorder_buffer import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             dispatch_valid,
    input  op_e              dispatch_op,
    input  logic [REG_W-1:0] dispatch_dest,
    input  logic [XLEN-1:0]  dispatch_a,
    input  logic [XLEN-1:0]  dispatch_b,
    output logic             dispatch_stall,
    output logic             issue_alu,
    output logic             issue_mul,
    output logic             issue_div,
    output op_e              issue_op,
    output logic [TAG_W-1:0] issue_tag,
    output logic [XLEN-1:0]  issue_a,
    output logic [XLEN-1:0]  issue_b,
    input  logic             alu_busy,
    input  logic             mul_busy,
    input  logic             div_busy,
    input  logic             cmp_valid,
    input  logic [TAG_W-1:0] cmp_tag,
    input  logic [XLEN-1:0]  cmp_value,
    output logic             commit_valid,
    output logic [REG_W-1:0] commit_dest,
    output logic [XLEN-1:0]  commit_value
);

    logic [ROB_DEPTH-1:0] rdy_q;              // Result written back
    logic [REG_W-1:0]     dest_q [ROB_DEPTH];
    logic [XLEN-1:0]      value_q [ROB_DEPTH];
    logic [TAG_W-1:0]     head_q;             // Oldest entry
    logic [TAG_W-1:0]     tail_q;             // Next free entry, also the new tag
    logic [TAG_W:0]       count_q;            // Occupied entries

    unit_e target;
    logic  full;
    logic  unit_busy;
    logic  take;
    logic  retire;

    assign target = unit_of(dispatch_op);
    assign full   = (count_q == (TAG_W+1)'(ROB_DEPTH));

    always_comb begin
        case (target)
            UNIT_MUL: unit_busy = mul_busy;
            UNIT_DIV: unit_busy = div_busy;
            default:  unit_busy = alu_busy;
        endcase
    end

    assign dispatch_stall = full || unit_busy;
    assign take           = dispatch_valid && !dispatch_stall;
    assign retire         = rdy_q[head_q];    // Head done, leave next edge

    // Issue goes out in the same cycle the entry is taken
    assign issue_alu = take && (target == UNIT_ALU);
    assign issue_mul = take && (target == UNIT_MUL);
    assign issue_div = take && (target == UNIT_DIV);
    assign issue_op  = dispatch_op;
    assign issue_tag = tail_q;
    assign issue_a   = dispatch_a;
    assign issue_b   = dispatch_b;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdy_q        <= '0;
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (take) begin
                rdy_q[tail_q] <= 1'b0;        // New entry waits for its result
                tail_q <= (tail_q == TAG_W'(ROB_DEPTH-1)) ? '0 : tail_q + 1'b1;
            end
            if (cmp_valid) begin
                rdy_q[cmp_tag] <= 1'b1;
            end
            if (retire) begin
                rdy_q[head_q] <= 1'b0;        // Free the slot
                head_q <= (head_q == TAG_W'(ROB_DEPTH-1)) ? '0 : head_q + 1'b1;
            end
            commit_valid <= retire;
            count_q <= count_q + {{TAG_W{1'b0}}, take} - {{TAG_W{1'b0}}, retire};
        end
    end

    // Entry payload and commit data
    always_ff @(posedge clk) begin
        if (take) begin
            dest_q[tail_q] <= dispatch_dest;
        end
        if (cmp_valid) begin
            value_q[cmp_tag] <= cmp_value;    // Written back by tag
        end
        if (retire) begin
            commit_dest  <= dest_q[head_q];
            commit_value <= value_q[head_q];
        end
    end

endmodule

`default_nettype wire

/* alu_unit.sv */
`default_nettype none

module alu_unit import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_alu,
    input  op_e              issue_op,
    input  logic [TAG_W-1:0] issue_tag,
    input  logic [XLEN-1:0]  issue_a,
    input  logic [XLEN-1:0]  issue_b,
    output logic             alu_busy,
    output logic             alu_done,
    output logic [TAG_W-1:0] alu_tag,
    output logic [XLEN-1:0]  alu_value,
    input  logic             alu_grant
);

    logic [XLEN-1:0] result;

    always_comb begin
        case (issue_op)
            OP_ADD:  result = issue_a + issue_b;
            OP_SUB:  result = issue_a - issue_b;
            OP_AND:  result = issue_a & issue_b;
            OP_OR:   result = issue_a | issue_b;
            OP_XOR:  result = issue_a ^ issue_b;
            OP_SLL:  result = issue_a << issue_b[4:0];  // Low five bits only
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            alu_done <= 1'b0;
        end else if (issue_alu) begin
            alu_done <= 1'b1;                 // May refill on the grant cycle
        end else if (alu_grant) begin
            alu_done <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_alu) begin
            alu_tag   <= issue_tag;
            alu_value <= result;
        end
    end

    assign alu_busy = alu_done && !alu_grant; // Held result blocks new issue

endmodule

`default_nettype wire

/* mul_unit.sv */
`default_nettype none

module mul_unit import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_mul,
    input  op_e              issue_op,
    input  logic [TAG_W-1:0] issue_tag,
    input  logic [XLEN-1:0]  issue_a,
    input  logic [XLEN-1:0]  issue_b,
    output logic             mul_busy,
    output logic             mul_done,
    output logic [TAG_W-1:0] mul_tag,
    output logic [XLEN-1:0]  mul_value,
    input  logic             mul_grant
);

    logic [MUL_STAGES-1:0] vld_q;             // One bit per stage
    logic [TAG_W-1:0]      tag_q [MUL_STAGES];
    logic [XLEN-1:0]       a_q;               // Stage 1 operands
    logic [XLEN-1:0]       b_q;
    logic [XLEN-1:0]       plo_q;             // Stage 2 a times b low half
    logic [XLEN/2-1:0]     phi_q;             // Stage 2 a times b high half, low bits
    logic [XLEN-1:0]       prod_q;            // Stage 3 result
    logic                  advance;
    logic                  start;

    assign advance = !(vld_q[MUL_STAGES-1] && !mul_grant);  // Freeze whole pipe
    assign start   = issue_mul && (issue_op == OP_MUL);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
        end else if (advance) begin
            vld_q <= {vld_q[MUL_STAGES-2:0], start};
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            tag_q[0] <= issue_tag;
            for (int k = 1; k < MUL_STAGES; k++) begin
                tag_q[k] <= tag_q[k-1];
            end
            a_q    <= issue_a;
            b_q    <= issue_b;
            plo_q  <= a_q * {{(XLEN/2){1'b0}}, b_q[XLEN/2-1:0]};
            phi_q  <= a_q[XLEN/2-1:0] * b_q[XLEN-1:XLEN/2];  // Only bits below 32 survive
            prod_q <= plo_q + {phi_q, {(XLEN/2){1'b0}}};
        end
    end

    assign mul_done  = vld_q[MUL_STAGES-1];
    assign mul_tag   = tag_q[MUL_STAGES-1];
    assign mul_value = prod_q;
    assign mul_busy  = !advance;              // Stage 1 cannot take a new op

endmodule

`default_nettype wire

/* div_unit.sv */
`default_nettype none

module div_unit import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             issue_div,
    input  op_e              issue_op,
    input  logic [TAG_W-1:0] issue_tag,
    input  logic [XLEN-1:0]  issue_a,
    input  logic [XLEN-1:0]  issue_b,
    output logic             div_busy,
    output logic             div_done,
    output logic [TAG_W-1:0] div_tag,
    output logic [XLEN-1:0]  div_value,
    input  logic             div_grant
);

    logic            run_q;                   // Iterating
    logic [5:0]      cnt_q;                   // Quotient bits left
    logic [XLEN-1:0] rem_q;                   // Partial remainder
    logic [XLEN-1:0] quo_q;                   // Dividend shifts out, quotient in
    logic [XLEN-1:0] dsr_q;                   // Divisor
    logic            is_rem_q;                // REMU wants the remainder
    logic [XLEN:0]   shifted;
    logic [XLEN:0]   diff;

    assign shifted = {rem_q, quo_q[XLEN-1]};
    assign diff    = shifted - {1'b0, dsr_q}; // Top bit set means borrow

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            run_q    <= 1'b0;
            cnt_q    <= '0;
            div_done <= 1'b0;
        end else begin
            if (issue_div) begin
                run_q <= 1'b1;
                cnt_q <= 6'(XLEN);
            end else if (run_q && cnt_q == '0) begin
                run_q <= 1'b0;                // Last cycle picks the result
            end else if (run_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
            if (run_q && cnt_q == '0) begin
                div_done <= 1'b1;
            end else if (div_grant) begin
                div_done <= 1'b0;
            end
        end
    end

    // Zero divisor never borrows, so quotient is all ones and remainder the dividend
    always_ff @(posedge clk) begin
        if (issue_div) begin
            rem_q    <= '0;
            quo_q    <= issue_a;
            dsr_q    <= issue_b;
            is_rem_q <= (issue_op == OP_REMU);
            div_tag  <= issue_tag;
        end else if (run_q && cnt_q != '0) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];      // Subtract fits
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= shifted[XLEN-1:0];   // Restore
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end else if (run_q) begin
            div_value <= is_rem_q ? rem_q : quo_q;
        end
    end

    assign div_busy = run_q || (div_done && !div_grant);

endmodule

`default_nettype wire

/* completion_arbiter.sv */
`default_nettype none

module completion_arbiter import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             alu_done,
    input  logic [TAG_W-1:0] alu_tag,
    input  logic [XLEN-1:0]  alu_value,
    input  logic             mul_done,
    input  logic [TAG_W-1:0] mul_tag,
    input  logic [XLEN-1:0]  mul_value,
    input  logic             div_done,
    input  logic [TAG_W-1:0] div_tag,
    input  logic [XLEN-1:0]  div_value,
    output logic             alu_grant,
    output logic             mul_grant,
    output logic             div_grant,
    output logic             cmp_valid,
    output logic [TAG_W-1:0] cmp_tag,
    output logic [XLEN-1:0]  cmp_value
);

    unit_e      ptr_q;                        // First source to look at
    unit_e      sel;                          // Granted source
    logic [2:0] req;                          // Indexed by unit_e
    logic [2:0] gnt;

    assign req = {div_done, mul_done, alu_done};

    always_comb begin
        int idx;
        gnt = '0;
        sel = ptr_q;
        for (int k = 0; k < 3; k++) begin
            idx = (int'(ptr_q) + k) % 3;
            if (gnt == '0 && req[idx]) begin  // First requester wins
                gnt[idx] = 1'b1;
                sel      = unit_e'(idx);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ptr_q <= UNIT_ALU;
        end else if (cmp_valid) begin
            ptr_q <= (sel == UNIT_DIV) ? UNIT_ALU : unit_e'(sel + 2'd1);  // One past the winner
        end
    end

    assign alu_grant = gnt[UNIT_ALU];
    assign mul_grant = gnt[UNIT_MUL];
    assign div_grant = gnt[UNIT_DIV];
    assign cmp_valid = |gnt;

    always_comb begin
        case (sel)
            UNIT_MUL: begin cmp_tag = mul_tag; cmp_value = mul_value; end
            UNIT_DIV: begin cmp_tag = div_tag; cmp_value = div_value; end
            default:  begin cmp_tag = alu_tag; cmp_value = alu_value; end
        endcase
    end

endmodule

`default_nettype wire

/* exec_core.sv */
`default_nettype none

module exec_core import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             dispatch_valid,
    input  op_e              dispatch_op,
    input  logic [REG_W-1:0] dispatch_dest,
    input  logic [XLEN-1:0]  dispatch_a,
    input  logic [XLEN-1:0]  dispatch_b,
    output logic             dispatch_stall,
    output logic             commit_valid,
    output logic [REG_W-1:0] commit_dest,
    output logic [XLEN-1:0]  commit_value
);

    // Shared issue bus
    logic             issue_alu, issue_mul, issue_div;
    op_e              issue_op;
    logic [TAG_W-1:0] issue_tag;
    logic [XLEN-1:0]  issue_a, issue_b;

    // Unit results toward the arbiter
    logic             alu_busy, alu_done, alu_grant;
    logic [TAG_W-1:0] alu_tag;
    logic [XLEN-1:0]  alu_value;
    logic             mul_busy, mul_done, mul_grant;
    logic [TAG_W-1:0] mul_tag;
    logic [XLEN-1:0]  mul_value;
    logic             div_busy, div_done, div_grant;
    logic [TAG_W-1:0] div_tag;
    logic [XLEN-1:0]  div_value;

    // Completion bus back into the ROB
    logic             cmp_valid;
    logic [TAG_W-1:0] cmp_tag;
    logic [XLEN-1:0]  cmp_value;

    reorder_buffer u_rob (
        .clk, .rst,
        .dispatch_valid, .dispatch_op, .dispatch_dest, .dispatch_a, .dispatch_b,
        .dispatch_stall,
        .issue_alu, .issue_mul, .issue_div, .issue_op, .issue_tag, .issue_a, .issue_b,
        .alu_busy, .mul_busy, .div_busy,
        .cmp_valid, .cmp_tag, .cmp_value,
        .commit_valid, .commit_dest, .commit_value
    );

    alu_unit u_alu (
        .clk, .rst, .issue_alu, .issue_op, .issue_tag, .issue_a, .issue_b,
        .alu_busy, .alu_done, .alu_tag, .alu_value, .alu_grant
    );

    mul_unit u_mul (
        .clk, .rst, .issue_mul, .issue_op, .issue_tag, .issue_a, .issue_b,
        .mul_busy, .mul_done, .mul_tag, .mul_value, .mul_grant
    );

    div_unit u_div (
        .clk, .rst, .issue_div, .issue_op, .issue_tag, .issue_a, .issue_b,
        .div_busy, .div_done, .div_tag, .div_value, .div_grant
    );

    completion_arbiter u_arb (
        .clk, .rst,
        .alu_done, .alu_tag, .alu_value,
        .mul_done, .mul_tag, .mul_value,
        .div_done, .div_tag, .div_value,
        .alu_grant, .mul_grant, .div_grant,
        .cmp_valid, .cmp_tag, .cmp_value
    );

endmodule

`default_nettype wire

/* exec_core_checker.sv */
`default_nettype none

module exec_core_checker import ooo_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             dispatch_valid,
    input  logic             dispatch_stall,
    input  op_e              dispatch_op,
    input  logic [REG_W-1:0] dispatch_dest,
    input  logic [XLEN-1:0]  exp_value,
    input  logic [2:0]       test_id,
    input  logic             commit_valid,
    input  logic [REG_W-1:0] commit_dest,
    input  logic [XLEN-1:0]  commit_value,
    output int               errors,
    output int               accepted,
    output int               committed
);

    logic [REG_W-1:0] dest_q [$];             // Program order, oldest first
    logic [XLEN-1:0]  value_q [$];
    logic [2:0]       id_q [$];
    unit_e            unit_q [$];

    function automatic string test_label(input logic [2:0] id);
        case (id)
            3'd2:    return "alu_ops";
            3'd3:    return "in_order";
            3'd4:    return "div_corner";
            3'd5:    return "backpressure";
            default: return "reset";
        endcase
    endfunction

    always @(posedge clk) begin : compare
        logic [REG_W-1:0] d;
        logic [XLEN-1:0]  v;
        logic [2:0]       id;
        unit_e            u;
        if (!rst) begin
            if (commit_valid) begin           // Older than any dispatch on this edge
                if (dest_q.size() == 0) begin
                    $display("ERROR: commit to r%0d value %h with no instruction outstanding",
                             commit_dest, commit_value);
                    errors++;
                end else begin
                    d  = dest_q.pop_front();
                    v  = value_q.pop_front();
                    id = id_q.pop_front();
                    u  = unit_q.pop_front();
                    if (commit_value !== v) begin
                        $display("FAIL %s: %s result to r%0d expected %h actual %h",
                                 test_label(id), u.name(), d, v, commit_value);
                        errors++;
                    end
                    if (commit_dest !== d) begin
                        $display("FAIL %s: destination expected r%0d actual r%0d",
                                 test_label(id), d, commit_dest);
                        errors++;
                    end
                    committed++;
                end
            end
            if (dispatch_valid && !dispatch_stall) begin  // Taken on this edge
                dest_q.push_back(dispatch_dest);
                value_q.push_back(exp_value);
                id_q.push_back(test_id);
                unit_q.push_back(unit_of(dispatch_op));
                accepted++;
            end
        end
    end

endmodule

`default_nettype wire

/* exec_core_asserts.sv */
`default_nettype none

module exec_core_asserts import ooo_pkg::*; (
    input logic             clk,
    input logic             rst,
    input logic             dispatch_valid,
    input logic             dispatch_stall,
    input logic             commit_valid,
    input logic             cmp_valid,
    input logic [TAG_W-1:0] cmp_tag,
    input logic [TAG_W-1:0] head_q,
    input logic [TAG_W-1:0] tail_q,
    input logic [TAG_W:0]   count_q
);

    logic [TAG_W-1:0] age;                    // Distance of the completing tag from the head

    assign age = cmp_tag - head_q;            // Wraps with the table

    // Empty ROB has nothing to retire on the next edge
    assert property (@(posedge clk) disable iff (rst) count_q == '0 |=> !commit_valid)
        else $error("commit_valid rose although the reorder buffer was empty");

    assert property (@(posedge clk) disable iff (rst)
        dispatch_valid && dispatch_stall |=> $stable(tail_q))
        else $error("an instruction was taken while dispatch_stall was high");

    assert property (@(posedge clk) disable iff (rst) cmp_valid |-> {1'b0, age} < count_q)
        else $error("completion bus carried the tag of a free entry");

endmodule

bind reorder_buffer exec_core_asserts u_asserts (
    .clk, .rst, .dispatch_valid, .dispatch_stall, .commit_valid,
    .cmp_valid, .cmp_tag, .head_q, .tail_q, .count_q
);

`default_nettype wire

/* exec_core_tb.sv */
`default_nettype none

module exec_core_tb import ooo_pkg::*; ();

    logic             clk;
    logic             rst;
    logic             dispatch_valid;
    op_e              dispatch_op;
    logic [REG_W-1:0] dispatch_dest;
    logic [XLEN-1:0]  dispatch_a;
    logic [XLEN-1:0]  dispatch_b;
    logic             dispatch_stall;
    logic             commit_valid;
    logic [REG_W-1:0] commit_dest;
    logic [XLEN-1:0]  commit_value;
    logic [XLEN-1:0]  exp_value;             // Reference result of the op on the port
    logic [2:0]       test_id;
    int               chk_errors;
    int               accepted;
    int               committed;
    int               errors;                // Direct checks and timeouts
    int               stall_seen;

    exec_core uut (
        .clk, .rst,
        .dispatch_valid, .dispatch_op, .dispatch_dest, .dispatch_a, .dispatch_b,
        .dispatch_stall,
        .commit_valid, .commit_dest, .commit_value
    );

    exec_core_checker chk (
        .clk, .rst,
        .dispatch_valid, .dispatch_stall, .dispatch_op, .dispatch_dest,
        .exp_value, .test_id,
        .commit_valid, .commit_dest, .commit_value,
        .errors(chk_errors), .accepted, .committed
    );

    always #2 clk = ~clk;

    function automatic logic [XLEN-1:0] exp_result(input op_e op, input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_MUL:  return a * b;           // Low 32 bits
            OP_DIVU: return (b == '0) ? '1 : a / b;
            OP_REMU: return (b == '0) ? a : a % b;
            default: return '0;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0d actual %0d", name, exp, act);
            errors++;
        end
    endtask

    // Called at a falling edge, returns at the falling edge after the op is taken
    task automatic send(input op_e op, input logic [REG_W-1:0] dest,
                        input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        int waited;
        int limit;
        limit          = 4 * (XLEN + MUL_STAGES + 2);  // A few held results ahead
        waited         = 0;
        dispatch_valid = 1'b1;
        dispatch_op    = op;
        dispatch_dest  = dest;
        dispatch_a     = a;
        dispatch_b     = b;
        exp_value      = exp_result(op, a, b);
        #1;                                  // Stall settles after the drive
        if (dispatch_stall) begin
            stall_seen++;
        end
        while (dispatch_stall && waited < limit) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (dispatch_stall) begin
            $display("ERROR: dispatch of %s to r%0d still stalled after %0d cycles",
                     op.name(), dest, limit);
            errors++;
        end
        @(negedge clk);
        dispatch_valid = 1'b0;
    endtask

    task automatic drain(input int limit);
        int waited;
        waited = 0;
        while (accepted != committed && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        if (accepted != committed) begin
            $display("ERROR: %0d instructions not committed after %0d cycles",
                     accepted - committed, limit);
            errors++;
        end
    endtask

    initial begin
        int base_acc;
        int base_com;
        clk            = 1'b0;
        rst            = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_op    = OP_ADD;
        dispatch_dest  = '0;
        dispatch_a     = '0;
        dispatch_b     = '0;
        exp_value      = '0;
        test_id        = 3'd1;
        errors         = 0;
        stall_seen     = 0;
        void'($urandom(32'he868));
        repeat (10) @(negedge clk);
        rst = 1'b0;

        // Idle after reset
        for (int k = 0; k < 20; k++) begin
            @(negedge clk);
            check_value("reset commit_valid", '0, {31'd0, commit_valid});
            check_value("reset dispatch_stall", '0, {31'd0, dispatch_stall});
        end

        test_id = 3'd2;
        for (int k = 0; k <= int'(OP_SLL); k++) begin
            send(op_e'(k), 5'(k), 32'h0000_0005, 32'h0000_0003);
            send(op_e'(k), 5'(k + 8), 32'hffff_ffff, 32'h8000_0021);  // SLL uses 1
            for (int r = 0; r < 4; r++) begin
                send(op_e'(k), 5'($urandom), $urandom, $urandom);
            end
        end
        drain(200);

        // Mixed units, completions return out of order
        test_id = 3'd3;
        for (int k = 0; k < 200; k++) begin
            send(op_e'($urandom_range(0, 8)), 5'($urandom), $urandom,
                 $urandom >> $urandom_range(0, 31));
        end
        drain(ROB_DEPTH * (XLEN + 8));

        test_id = 3'd4;
        send(OP_DIVU, 5'd1, 32'h1234_5678, 32'd0);
        send(OP_REMU, 5'd2, 32'h1234_5678, 32'd0);
        send(OP_DIVU, 5'd3, 32'd0, 32'd7);
        send(OP_REMU, 5'd4, 32'd0, 32'd7);
        send(OP_DIVU, 5'd5, 32'd0, 32'd0);
        send(OP_REMU, 5'd6, 32'd0, 32'd0);
        send(OP_DIVU, 5'd7, 32'hffff_ffff, 32'd1);
        send(OP_REMU, 5'd8, 32'hffff_ffff, 32'd10);
        drain(12 * (XLEN + 4));

        // Divider stays busy so the ALU ops behind it must wait
        test_id    = 3'd5;
        stall_seen = 0;
        base_acc   = accepted;
        base_com   = committed;
        for (int k = 0; k < 4; k++) begin
            send(OP_DIVU, 5'(k + 16), $urandom, $urandom_range(1, 1000));
        end
        for (int k = 0; k < 8; k++) begin
            send(op_e'($urandom_range(0, 5)), 5'(k), $urandom, $urandom);
        end
        drain(8 * (XLEN + 4));
        check_value("backpressure stall seen", 1, {31'd0, stall_seen > 0});
        check_value("backpressure accepted", 12, accepted - base_acc);
        check_value("backpressure committed", 12, committed - base_com);

        repeat (5) @(negedge clk);
        $display("Summary: %0d compare errors, %0d testbench errors, %0d of %0d committed",
                 chk_errors, errors, committed, accepted);
        if (chk_errors == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* exec_core.f */
ooo_pkg.sv
reorder_buffer.sv
alu_unit.sv
mul_unit.sv
div_unit.sv
completion_arbiter.sv
exec_core.sv
exec_core_checker.sv
exec_core_asserts.sv
exec_core_tb.sv

/* Makefile */
TOP = exec_core_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f exec_core.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	@if grep -q "TEST RESULT: FAIL" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "TEST RESULT: PASS" sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf obj_dir sim.log
